//--- rtl/ulpb_pkg.sv
package ulpb_pkg;

	// Message field widths.
	localparam int addr_width = 8;
	localparam int data_width = 32;
	localparam int id_width   = 4;
	localparam int op_width   = addr_width - id_width;

	// Short address of this node, compared against the upper address nibble.
	localparam logic [id_width-1:0] node_id = 4'h5;

	typedef logic [addr_width-1:0] addr_t;
	typedef logic [data_width-1:0] data_t;

	// Command carried in the lower address nibble.
	typedef enum logic [op_width-1:0]
	{
		op_write = 4'h0,
		op_read  = 4'h1,
		op_sleep = 4'h2
	} ulpb_op_e;

	// Isolation levels for every power control.
	localparam logic io_hold    = 1'b0;
	localparam logic io_release = 1'b1;

	typedef enum logic [1:0]
	{
		sl_asleep,
		sl_waking,
		sl_awake
	} sleep_state_e;

	typedef enum logic [2:0]
	{
		bc_idle,
		bc_power_up,
		bc_deliver,
		bc_wait_resp,
		bc_reply,
		bc_sleep_req
	} bc_state_e;

endpackage

//--- rtl/ulpb_lc_if.sv
`timescale 1ns/100ps

interface ulpb_lc_if
	import ulpb_pkg::*;
();

	// Transmit group, layer side toward bus side.
	addr_t tx_addr;
	data_t tx_data;
	logic  tx_req;
	logic  tx_ack;
	logic  tx_succ;
	logic  tx_fail;
	logic  tx_resp_ack;

	// Receive group, bus side toward layer side.
	addr_t rx_addr;
	data_t rx_data;
	logic  rx_req;
	logic  rx_ack;

	// Power controls of the layer domain.
	logic  power_on;
	logic  release_clk;
	logic  release_rst;
	logic  release_iso;

	modport bus
	(
		output rx_addr, rx_data, rx_req, tx_ack, tx_succ, tx_fail,
		output power_on, release_clk, release_rst, release_iso,
		input  tx_addr, tx_data, tx_req, tx_resp_ack, rx_ack
	);

	modport layer
	(
		input  rx_addr, rx_data, rx_req, tx_ack, tx_succ, tx_fail,
		input  power_on, release_clk, release_rst, release_iso,
		output tx_addr, tx_data, tx_req, tx_resp_ack, rx_ack
	);

endinterface

//--- rtl/ulpb_sleep_ctrl.sv
`timescale 1ns/100ps

module ulpb_sleep_ctrl
	import ulpb_pkg::*;
#(
	parameter int wake_cycles = 4
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic wakeup,
	input  logic sleep_req,
	output logic iso_release,
	output logic asleep
);

	localparam int cnt_width = $clog2(wake_cycles + 1);

	sleep_state_e         state;
	logic [cnt_width-1:0] wake_cnt;

	assign asleep = (state == sl_asleep);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state       <= sl_asleep;
			wake_cnt    <= '0;
			iso_release <= io_hold;
		end
		else
		begin
			case (state)
				sl_asleep:
				begin
					if (wakeup)
					begin
						state    <= sl_waking;
						wake_cnt <= cnt_width'(1);
					end
				end
				sl_waking:
				begin
					// Isolation stays held until the bus side has settled.
					if (wake_cnt == cnt_width'(wake_cycles))
					begin
						state       <= sl_awake;
						iso_release <= io_release;
					end
					else
					begin
						wake_cnt <= wake_cnt + 1'b1;
					end
				end
				sl_awake:
				begin
					if (sleep_req)
					begin
						state       <= sl_asleep;
						iso_release <= io_hold;
					end
				end
				default:
				begin
					state       <= sl_asleep;
					iso_release <= io_hold;
				end
			endcase
		end
	end

	// Isolation register never disagrees with the sleep state.
	assert property (@(posedge clk) disable iff (!rst_n)
		asleep |-> (iso_release == io_hold))
		else $error("iso_release at release while asleep");

	// Wake delay is exact
	assert property (@(posedge clk) disable iff (!rst_n)
		(asleep && wakeup) |=>
			(iso_release == io_hold) [*wake_cycles] ##1 (iso_release == io_release))
		else $error("iso_release not released wake_cycles after wakeup");

endmodule

//--- rtl/ulpb_bus_ctrl.sv
`timescale 1ns/100ps

module ulpb_bus_ctrl
	import ulpb_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   iso_release,
	input  logic   msg_valid,
	input  addr_t  msg_addr,
	input  data_t  msg_data,
	output logic   msg_ready,
	output logic   out_valid,
	output addr_t  out_addr,
	output data_t  out_data,
	input  logic   out_ready,
	output logic   sleep_req,
	ulpb_lc_if.bus lc
);

	bc_state_e state;
	ulpb_op_e  op;
	logic      accept;
	logic      take_reply;

	assign msg_ready  = (state == bc_idle) && (iso_release == io_release);
	assign accept     = msg_valid && msg_ready &&
		(msg_addr[addr_width-1 -: id_width] == node_id);
	assign take_reply = (state == bc_wait_resp) && lc.tx_req;
	assign sleep_req  = (state == bc_sleep_req);

	// Command of the message held on the receive lines.
	assign op = ulpb_op_e'(lc.rx_addr[op_width-1:0]);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state          <= bc_idle;
			lc.power_on    <= io_hold;
			lc.release_clk <= io_hold;
			lc.release_rst <= io_hold;
			lc.release_iso <= io_hold;
			lc.rx_req      <= 1'b0;
			lc.tx_ack      <= 1'b0;
			lc.tx_succ     <= 1'b0;
			lc.tx_fail     <= 1'b0;
			out_valid      <= 1'b0;
		end
		else
		begin
			case (state)
				bc_idle:
				begin
					// Layer domain down means power it up before delivery.
					if (accept && (lc.release_iso == io_hold))
					begin
						lc.power_on <= io_release;
						state       <= bc_power_up;
					end
					else if (accept)
					begin
						lc.rx_req <= 1'b1;
						state     <= bc_deliver;
					end
				end
				bc_power_up:
				begin
					if (lc.release_clk == io_hold)
					begin
						lc.release_clk <= io_release;
					end
					else if (lc.release_rst == io_hold)
					begin
						lc.release_rst <= io_release;
					end
					else
					begin
						lc.release_iso <= io_release;
						lc.rx_req      <= 1'b1;
						state          <= bc_deliver;
					end
				end
				bc_deliver:
				begin
					if (lc.rx_req && lc.rx_ack)
					begin
						lc.rx_req <= 1'b0;
					end
					else if (!lc.rx_req && !lc.rx_ack)
					begin
						case (op)
							op_read:
								state <= bc_wait_resp;
							op_sleep:
							begin
								lc.power_on    <= io_hold;
								lc.release_clk <= io_hold;
								lc.release_rst <= io_hold;
								lc.release_iso <= io_hold;
								state          <= bc_sleep_req;
							end
							default:
								state <= bc_idle;
						endcase
					end
				end
				bc_wait_resp:
				begin
					// A zero node id is an illegal destination and never leaves.
					if (take_reply)
					begin
						lc.tx_ack <= 1'b1;
						out_valid <= (lc.tx_addr[addr_width-1 -: id_width] != '0);
						state     <= bc_reply;
					end
				end
				bc_reply:
				begin
					if (lc.tx_succ || lc.tx_fail)
					begin
						if (lc.tx_resp_ack)
						begin
							lc.tx_ack  <= 1'b0;
							lc.tx_succ <= 1'b0;
							lc.tx_fail <= 1'b0;
							state      <= bc_idle;
						end
					end
					else if (out_valid)
					begin
						if (out_ready)
						begin
							out_valid  <= 1'b0;
							lc.tx_succ <= 1'b1;
						end
					end
					else
					begin
						lc.tx_fail <= 1'b1;
					end
				end
				bc_sleep_req:
				begin
					// Wait for the sleep controller to take the node down.
					if (iso_release == io_hold)
						state <= bc_idle;
				end
				default:
					state <= bc_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			lc.rx_addr <= msg_addr;
			lc.rx_data <= msg_data;
		end
		if (take_reply)
		begin
			out_addr <= lc.tx_addr;
			out_data <= lc.tx_data;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(lc.rx_req && !lc.rx_ack) |=> lc.rx_req)
		else $error("rx_req dropped before rx_ack");

endmodule

//--- rtl/ulpb_node_isolation.sv
`timescale 1ns/100ps

module ulpb_node_isolation
	import ulpb_pkg::*;
(
	input  logic     iso_release,
	ulpb_lc_if.layer bc,
	ulpb_lc_if.bus   lc
);

	// Bus controller's release_iso after the sleep controller's hold.
	logic bc_iso_masked;

	// Power controls toward the layer domain.
	always_comb
	begin
		if (iso_release == io_hold)
		begin
			lc.power_on    = io_hold;
			lc.release_clk = io_hold;
			lc.release_rst = io_hold;
		end
		else
		begin
			lc.power_on    = bc.power_on;
			lc.release_clk = bc.release_clk;
			lc.release_rst = bc.release_rst;
		end
	end

	// Signals toward the layer side.
	always_comb
	begin
		if (iso_release == io_hold)
		begin
			lc.rx_addr    = '0;
			lc.rx_data    = '0;
			lc.rx_req     = 1'b0;
			lc.tx_ack     = 1'b0;
			lc.tx_succ    = 1'b0;
			lc.tx_fail    = 1'b0;
			bc_iso_masked = io_hold;
		end
		else
		begin
			lc.rx_addr    = bc.rx_addr;
			lc.rx_data    = bc.rx_data;
			lc.rx_req     = bc.rx_req;
			lc.tx_ack     = bc.tx_ack;
			lc.tx_succ    = bc.tx_succ;
			lc.tx_fail    = bc.tx_fail;
			bc_iso_masked = bc.release_iso;
		end
		lc.release_iso = bc_iso_masked;
	end

	// Signals toward the bus side, gated by the masked release.
	always_comb
	begin
		if (bc_iso_masked == io_hold)
		begin
			bc.tx_addr     = '0;
			bc.tx_data     = '0;
			bc.tx_req      = 1'b0;
			bc.tx_resp_ack = 1'b0;
			bc.rx_ack      = 1'b0;
		end
		else
		begin
			bc.tx_addr     = lc.tx_addr;
			bc.tx_data     = lc.tx_data;
			bc.tx_req      = lc.tx_req;
			bc.tx_resp_ack = lc.tx_resp_ack;
			bc.rx_ack      = lc.rx_ack;
		end
	end

	// Layer side only ever sees a request rise with the node released.
	assert property (@(posedge lc.rx_req) iso_release == io_release)
		else $error("rx_req reached layer side while isolation held");

endmodule

//--- rtl/ulpb_layer_ctrl.sv
`timescale 1ns/100ps

module ulpb_layer_ctrl
	import ulpb_pkg::*;
#(
	parameter int reg_depth = 8
)
(
	input  logic     clk,
	input  logic     rst_n,
	ulpb_lc_if.layer ifc
);

	// Index fits inside the upper nibble, so depth is at most 16.
	localparam int idx_width = $clog2(reg_depth);

	typedef enum logic [1:0]
	{
		lc_idle,
		lc_rx_done,
		lc_tx_wait,
		lc_tx_done
	} lc_state_e;

	lc_state_e            state;
	data_t                regs [reg_depth];
	logic                 rd_pend;
	logic                 domain_on;
	logic                 run;
	logic                 rx_take;
	ulpb_op_e             op;
	logic [idx_width-1:0] wr_idx;
	logic [idx_width-1:0] rd_idx;

	assign domain_on = (ifc.power_on == io_release) && (ifc.release_rst == io_release);
	assign run       = domain_on && (ifc.release_clk == io_release);
	assign rx_take   = run && (state == lc_idle) && ifc.rx_req &&
		(ifc.release_iso == io_release);
	assign op        = ulpb_op_e'(ifc.rx_addr[op_width-1:0]);

	// Writes index from just above bit 27, reads from the low bits.
	assign wr_idx = ifc.rx_data[28 +: idx_width];
	assign rd_idx = ifc.rx_data[idx_width-1:0];

	always_ff @(posedge clk)
	begin
		if (!rst_n || !domain_on)
		begin
			state           <= lc_idle;
			rd_pend         <= 1'b0;
			ifc.rx_ack      <= 1'b0;
			ifc.tx_req      <= 1'b0;
			ifc.tx_resp_ack <= 1'b0;
		end
		else if (run)
		begin
			case (state)
				lc_idle:
				begin
					// Every command is acknowledged, sleep needs nothing more.
					if (rx_take)
					begin
						ifc.rx_ack <= 1'b1;
						rd_pend    <= (op == op_read);
						state      <= lc_rx_done;
					end
				end
				lc_rx_done:
				begin
					if (!ifc.rx_req)
					begin
						ifc.rx_ack <= 1'b0;
						ifc.tx_req <= rd_pend;
						state      <= rd_pend ? lc_tx_wait : lc_idle;
					end
				end
				lc_tx_wait:
				begin
					if (ifc.tx_ack && (ifc.tx_succ || ifc.tx_fail))
					begin
						ifc.tx_req      <= 1'b0;
						ifc.tx_resp_ack <= 1'b1;
						rd_pend         <= 1'b0;
						state           <= lc_tx_done;
					end
				end
				lc_tx_done:
				begin
					if (!ifc.tx_succ && !ifc.tx_fail)
					begin
						ifc.tx_resp_ack <= 1'b0;
						state           <= lc_idle;
					end
				end
				default:
					state <= lc_idle;
			endcase
		end
	end

	// Register contents are lost whenever the layer domain is reset.
	always_ff @(posedge clk)
	begin
		if (!rst_n || (ifc.release_rst == io_hold))
		begin
			for (int i = 0; i < reg_depth; i++)
				regs[i] <= '0;
		end
		else if (rx_take && (op == op_write))
		begin
			regs[wr_idx] <= ifc.rx_data;
		end
	end

	// Reply goes to the requested node as a write.
	always_ff @(posedge clk)
	begin
		if (rx_take && (op == op_read))
		begin
			ifc.tx_addr <= {ifc.rx_data[data_width-1 -: id_width], op_write};
			ifc.tx_data <= regs[rd_idx];
		end
	end

endmodule

//--- rtl/ulpb_node_top.sv
`timescale 1ns/100ps

module ulpb_node_top
	import ulpb_pkg::*;
#(
	parameter int reg_depth   = 8,
	parameter int wake_cycles = 4
)
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  wakeup,
	input  logic  msg_valid,
	input  addr_t msg_addr,
	input  data_t msg_data,
	output logic  msg_ready,
	output logic  out_valid,
	output addr_t out_addr,
	output data_t out_data,
	input  logic  out_ready,
	output logic  asleep
);

	logic iso_release;
	logic sleep_req;

	// Bus controller to isolation, and isolation to layer controller.
	ulpb_lc_if bc_side ();
	ulpb_lc_if lc_side ();

	ulpb_sleep_ctrl #(
		.wake_cycles (wake_cycles)
	) ulpb_sleep_ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.wakeup      (wakeup),
		.sleep_req   (sleep_req),
		.iso_release (iso_release),
		.asleep      (asleep)
	);

	ulpb_bus_ctrl ulpb_bus_ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.iso_release (iso_release),
		.msg_valid   (msg_valid),
		.msg_addr    (msg_addr),
		.msg_data    (msg_data),
		.msg_ready   (msg_ready),
		.out_valid   (out_valid),
		.out_addr    (out_addr),
		.out_data    (out_data),
		.out_ready   (out_ready),
		.sleep_req   (sleep_req),
		.lc          (bc_side.bus)
	);

	ulpb_node_isolation ulpb_node_isolation_i (
		.iso_release (iso_release),
		.bc          (bc_side.layer),
		.lc          (lc_side.bus)
	);

	ulpb_layer_ctrl #(
		.reg_depth (reg_depth)
	) ulpb_layer_ctrl_i (
		.clk   (clk),
		.rst_n (rst_n),
		.ifc   (lc_side.layer)
	);

endmodule

//--- sim/ulpb_node_tb.sv
`timescale 1ns/100ps

module ulpb_node_tb
	import ulpb_pkg::*;
();

	localparam int reg_depth   = 8;
	localparam int wake_cycles = 4;
	localparam int idx_width   = $clog2(reg_depth);
	localparam int wait_limit  = 200;

	logic  clk;
	logic  rst_n;
	logic  wakeup;
	logic  msg_valid;
	addr_t msg_addr;
	data_t msg_data;
	logic  msg_ready;
	logic  out_valid;
	addr_t out_addr;
	data_t out_data;
	logic  out_ready;
	logic  asleep;

	// Expected register contents and the reply awaited next.
	data_t model [reg_depth];
	addr_t exp_addr;
	data_t exp_data;

	// Set once the first wakeup has been driven.
	bit woken;

	int reads_sent;
	int replies_seen;
	int errors;
	int errors_before;
	int tests_run;
	int tests_failed;

	ulpb_node_top #(
		.reg_depth   (reg_depth),
		.wake_cycles (wake_cycles)
	) ulpb_node_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.wakeup    (wakeup),
		.msg_valid (msg_valid),
		.msg_addr  (msg_addr),
		.msg_data  (msg_data),
		.msg_ready (msg_ready),
		.out_valid (out_valid),
		.out_addr  (out_addr),
		.out_data  (out_data),
		.out_ready (out_ready),
		.asleep    (asleep)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Counts completed reply transfers on the outgoing port.
	always @(posedge clk)
	begin
		if (!rst_n)
			replies_seen <= 0;
		else if (out_valid && out_ready)
			replies_seen <= replies_seen + 1;
	end

	task automatic report_error(input string msg);
		errors++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	task automatic abort_run(input string why);
		$display("Run aborted: %s", why);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// Until the first wakeup the node reports itself asleep.
	assert property (@(posedge clk) disable iff (!rst_n)
		!woken |-> asleep)
		else report_error("asleep low before the first wakeup");

	// A sleeping node offers no handshake on either port.
	assert property (@(posedge clk) disable iff (!rst_n)
		asleep |-> (!msg_ready && !out_valid))
		else report_error("msg_ready or out_valid high while asleep");

	assert property (@(posedge clk) disable iff (!rst_n)
		(asleep && wakeup) |=> !msg_ready [*wake_cycles])
		else report_error("msg_ready rose before the wake delay ended");

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> ((out_addr == exp_addr) && (out_data == exp_data)))
		else report_error($sformatf("reply %h/%h, expected %h/%h",
			out_addr, out_data, exp_addr, exp_data));

	// Every reply must belong to a read still waiting for one.
	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (replies_seen < reads_sent))
		else report_error("reply without a pending read");

	assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=>
			(out_valid && $stable(out_addr) && $stable(out_data)))
		else report_error("reply changed while stalled");

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic pulse_wakeup();
		wakeup = 1'b1;
		woken  = 1'b1;
		@(posedge clk);
		#1;
		wakeup = 1'b0;
	endtask

	// msg_ready is a register output, stable from here to the next edge.
	task automatic send_msg(input addr_t addr, input data_t data);
		bit done;
		int n;
		done      = 1'b0;
		n         = 0;
		msg_valid = 1'b1;
		msg_addr  = addr;
		msg_data  = data;
		while (!done && (n < wait_limit))
		begin
			done = msg_ready;
			@(posedge clk);
			#1;
			n++;
		end
		msg_valid = 1'b0;
		if (!done)
			abort_run($sformatf("message %h was never accepted", addr));
	endtask

	task automatic write_reg(input int idx);
		data_t data;
		data = $urandom;
		// The write index sits just above bit 27 of the data word.
		data[28 +: idx_width] = idx_width'(idx);
		send_msg({node_id, op_write}, data);
		model[idx] = data;
	endtask

	task automatic read_reg(input int idx, input bit stall);
		logic [id_width-1:0] dest;
		bit                  got;
		int                  n;
		dest     = id_width'($urandom_range(15, 1));
		exp_addr = {dest, op_write};
		exp_data = model[idx];
		send_msg({node_id, op_read}, {dest, 24'h0, 4'(idx)});
		reads_sent++;
		got = 1'b0;
		n   = 0;
		while (!got && (n < wait_limit))
		begin
			out_ready = stall ? 1'($urandom_range(1, 0)) : 1'b1;
			got       = out_valid && out_ready;
			@(posedge clk);
			#1;
			n++;
		end
		out_ready = 1'b1;
		if (!got)
			abort_run($sformatf("no reply to the read of register %0d", idx));
	endtask

	task automatic wait_asleep();
		int n;
		n = 0;
		while (!asleep && (n < wait_limit))
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!asleep)
			abort_run("node did not go to sleep after a sleep command");
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != errors_before)
		begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end
		else
		begin
			$display("test %0d %s: ok", tests_run, name);
		end
		errors_before = errors;
	endtask

	initial
	begin
		data_t stray;
		void'($urandom(32'h6297_02f2));
		rst_n         = 1'b0;
		wakeup        = 1'b0;
		woken         = 1'b0;
		msg_valid     = 1'b0;
		msg_addr      = '0;
		msg_data      = '0;
		out_ready     = 1'b1;
		reads_sent    = 0;
		errors        = 0;
		errors_before = 0;
		tests_run     = 0;
		tests_failed  = 0;
		for (int i = 0; i < reg_depth; i++)
			model[i] = '0;

		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// A message offered to a sleeping node must be ignored.
		idle_cycles(3);
		msg_valid = 1'b1;
		msg_addr  = {node_id, op_read};
		msg_data  = {4'h1, 28'h0};
		idle_cycles(8);
		msg_valid = 1'b0;
		finish_test("asleep after reset");

		pulse_wakeup();
		write_reg(0);
		read_reg(0, 1'b0);
		finish_test("wake and power-up");

		for (int i = 0; i < reg_depth; i++)
			write_reg(i);
		for (int i = 0; i < reg_depth; i++)
			read_reg(i, 1'b0);
		finish_test("write and read every register");

		stray = $urandom;
		stray[28 +: idx_width] = idx_width'(2);
		send_msg({4'h3, op_write}, stray);
		send_msg({4'h3, op_read}, {4'h1, 24'h0, 4'h2});
		idle_cycles(20);
		read_reg(2, 1'b0);
		finish_test("foreign node id dropped");

		for (int i = 0; i < reg_depth; i++)
			read_reg(i, 1'b1);
		finish_test("reply back-pressure");

		send_msg({node_id, op_sleep}, '0);
		wait_asleep();
		// The layer reset clears the whole register file.
		for (int i = 0; i < reg_depth; i++)
			model[i] = '0;
		idle_cycles(3);
		pulse_wakeup();
		read_reg(int'($urandom_range(reg_depth - 1, 0)), 1'b0);
		finish_test("sleep clears registers");

		assert (replies_seen == reads_sent)
			else report_error("reply count differs from read count");

		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- sim.f
rtl/ulpb_pkg.sv
rtl/ulpb_lc_if.sv
rtl/ulpb_sleep_ctrl.sv
rtl/ulpb_bus_ctrl.sv
rtl/ulpb_node_isolation.sv
rtl/ulpb_layer_ctrl.sv
rtl/ulpb_node_top.sv
sim/ulpb_node_tb.sv

//--- Bender.yml
package:
  name: ulpb_node

sources:
  - rtl/ulpb_pkg.sv
  - rtl/ulpb_lc_if.sv
  - rtl/ulpb_sleep_ctrl.sv
  - rtl/ulpb_bus_ctrl.sv
  - rtl/ulpb_node_isolation.sv
  - rtl/ulpb_layer_ctrl.sv
  - rtl/ulpb_node_top.sv
  - target: simulation
    files:
      - sim/ulpb_node_tb.sv
